// File: compile.f
rtl/mem_map_pkg.sv
rtl/bus_pkg.sv
rtl/bank_if.sv
rtl/mem_req_router.sv
rtl/mem_bank.sv
rtl/rsp_merger.sv
rtl/text_buffer.sv
rtl/cpu_mem_interface.sv
testbench/tb_cpu_mem_interface.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f compile.f \
    --top-module tb_cpu_mem_interface \
    -o sim_tb

./obj_dir/sim_tb

// File: testbench/tb_cpu_mem_interface.sv
`timescale 1ns/10ps

module tb_cpu_mem_interface import mem_map_pkg::*, bus_pkg::*; ();

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WORDS   = 64;
    localparam int BANK_CREDITS = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int N_INIT       = NUM_BANKS * BANK_WORDS;
    localparam int N_WR_RD      = 12;
    localparam int N_BP         = 3 * BANK_CREDITS;
    localparam int N_RANDOM     = 300;
    // reads take several cycles, writes mostly one
    localparam int STIM_CYCLES  = N_INIT + 6 * (2 * N_WR_RD + 2 * N_BP + N_RANDOM) + 40;

    logic               ui_clk;
    logic               rst_n;
    logic               dmem_read;
    logic               dmem_write;
    logic [ADDR_W-1:0]  dmem_addr;
    logic [DATA_W-1:0]  dmem_wdata;
    logic [BE_W-1:0]    dmem_be;
    logic [DATA_W-1:0]  dmem_rdata;
    logic               mem_stall;
    logic [CHAR_AW-1:0] disp_addr;
    logic [7:0]         disp_char;

    logic [31:0]        lfsr;
    string              test_name;
    logic [DATA_W-1:0]  shadow_mem [NUM_BANKS][BANK_WORDS];
    logic [7:0]         shadow_text [2**CHAR_AW];

    // check strobes and the values they compare
    logic               reset_window;
    logic               chk_rd;
    logic               chk_fast;
    logic               chk_disp;
    logic               chk_bp;
    logic               stall_seen;
    logic [DATA_W-1:0]  exp_rdata;
    logic [7:0]         exp_char;

    // outputs captured at the falling edge
    logic               stall_q;
    logic [DATA_W-1:0]  rdata_q;
    logic [7:0]         char_q;

    cpu_mem_interface #(
        .NUM_BANKS    (NUM_BANKS),
        .BANK_WORDS   (BANK_WORDS),
        .BANK_CREDITS (BANK_CREDITS)
    ) u_dut (
        .ui_clk     (ui_clk),
        .rst_n      (rst_n),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_rdata (dmem_rdata),
        .mem_stall  (mem_stall),
        .disp_addr  (disp_addr),
        .disp_char  (disp_char)
    );

    initial begin
        ui_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ui_clk = ~ui_clk;
    end

    always @(negedge ui_clk) begin
        stall_q <= mem_stall;
        rdata_q <= dmem_rdata;
        char_q  <= disp_char;
    end

    ////////////////////////////////////////
    // error reporting and watchdog
    ////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
        $display("** FAIL **");
        $fatal(1, "value mismatch");
    endtask

    task automatic stop_run(input string why);
        $display("%s (test %s)", why, test_name);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        #((4 * STIM_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        stop_run("watchdog expired, the DUT stopped completing accesses");
    end

    a_reset_quiet: assert property (@(posedge ui_clk) reset_window |-> !stall_q)
        else report_mismatch("mem_stall", 32'd0, 32'(stall_q));

    a_read_data: assert property (@(posedge ui_clk) chk_rd |-> (rdata_q == exp_rdata))
        else report_mismatch("dmem_rdata", exp_rdata, rdata_q);

    a_fast_access: assert property (@(posedge ui_clk) chk_fast |-> !stall_q)
        else stop_run("an access outside main memory did not complete at once");

    a_display: assert property (@(posedge ui_clk) chk_disp |-> (char_q == exp_char))
        else report_mismatch("disp_char", 32'(exp_char), 32'(char_q));

    a_backpressure: assert property (@(posedge ui_clk) chk_bp |-> stall_seen)
        else stop_run("mem_stall never rose while one bank ran out of credits");

    ////////////////////////////////////////
    // stimulus helpers and shadow model
    ////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic in_main(input logic [ADDR_W-1:0] addr);
        return addr[REGION_HI:REGION_LO] <= 4'hb;
    endfunction

    function automatic int vmem_lane(input logic [BE_W-1:0] be);
        case (be)
            4'b1000: return 0;
            4'b0100: return 1;
            4'b0010: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic int char_index(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be);
        return (4 * int'(addr % (2**CHAR_AW)) + vmem_lane(be)) % (2**CHAR_AW);
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (!in_main(addr)) begin
            return '0;
        end
        return shadow_mem[int'(addr % NUM_BANKS)][int'((addr / NUM_BANKS) % BANK_WORDS)];
    endfunction

    function automatic void update_shadow(input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] data,
                                          input logic [BE_W-1:0] be);
        int bank;
        int word;
        bank = int'(addr % NUM_BANKS);
        word = int'((addr / NUM_BANKS) % BANK_WORDS);
        if (in_main(addr)) begin
            for (int i = 0; i < BE_W; i++) begin
                if (be[i]) begin
                    shadow_mem[bank][word][8*i +: 8] = data[8*i +: 8];
                end
            end
        end else if (addr[REGION_HI:REGION_LO] == 4'hc) begin
            shadow_text[char_index(addr, be)] = data[8*vmem_lane(be) +: 8];
        end
    endfunction

    // entered just after a rising edge, returns just after the completing edge
    task automatic cpu_access(input logic rd, input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
        dmem_read  = rd;
        dmem_write = wr;
        dmem_addr  = addr;
        dmem_wdata = wdata;
        dmem_be    = be;
        chk_fast   = !in_main(addr);
        @(negedge ui_clk);
        while (mem_stall) begin
            stall_seen = 1'b1;
            @(negedge ui_clk);
        end
        if (rd) begin
            exp_rdata = expected_word(addr);
            chk_rd    = 1'b1;
        end
        if (wr) begin
            update_shadow(addr, wdata, be);
        end
        @(posedge ui_clk);
        #1;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        chk_rd     = 1'b0;
        chk_fast   = 1'b0;
    endtask

    task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [BE_W-1:0] be);
        cpu_access(1'b0, 1'b1, addr, data, be);
    endtask

    task automatic cpu_read(input logic [ADDR_W-1:0] addr);
        cpu_access(1'b1, 1'b0, addr, '0, '0);
    endtask

    // disp_char is registered, so compare two edges later
    task automatic check_display(input int caddr);
        disp_addr = CHAR_AW'(caddr);
        @(posedge ui_clk);
        #1;
        exp_char = shadow_text[caddr];
        chk_disp = 1'b1;
        @(posedge ui_clk);
        #1;
        chk_disp = 1'b0;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic write_then_read();
        logic [ADDR_W-1:0] addrs [N_WR_RD];
        test_name = "write_read";
        for (int i = 0; i < N_WR_RD; i++) begin
            addrs[i] = ADDR_W'(lfsr_bits(28));
            cpu_write(addrs[i], lfsr_bits(32), BE_W'(lfsr_bits(4)));
        end
        for (int i = 0; i < N_WR_RD; i++) begin
            cpu_read(addrs[i]);
        end
    endtask

    task automatic overflow_bank_credits();
        test_name  = "backpressure";
        stall_seen = 1'b0;
        // every address lands in bank 1
        for (int k = 0; k < N_BP; k++) begin
            cpu_write(ADDR_W'(NUM_BANKS * (k + 1) + 1), lfsr_bits(32), 4'hf);
        end
        chk_bp = 1'b1;
        @(posedge ui_clk);
        #1;
        chk_bp = 1'b0;
        for (int k = 0; k < N_BP; k++) begin
            cpu_read(ADDR_W'(NUM_BANKS * (k + 1) + 1));
        end
    endtask

    task automatic write_video_lanes();
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        test_name = "video";
        for (int lane = 0; lane < 4; lane++) begin
            be   = 4'b1000 >> lane;
            addr = {4'hc, 26'(lfsr_bits(26))};
            cpu_write(addr, lfsr_bits(32), be);
            check_display(char_index(addr, be));
        end
        cpu_read({4'hc, 26'(lfsr_bits(26))});
    endtask

    task automatic access_io_windows();
        logic [25:0] low;
        test_name = "timer_kbd";
        low = 26'(lfsr_bits(26));
        cpu_read({4'hd, low});
        cpu_read({4'he, low});
        cpu_write({4'hd, low}, lfsr_bits(32), 4'hf);
        cpu_write({4'he, low}, lfsr_bits(32), 4'hf);
        cpu_read({4'h0, low});
    endtask

    task automatic mix_random_accesses();
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = ADDR_W'(lfsr_bits(ADDR_W));
            if (lfsr_bits(1) == 32'd1) begin
                cpu_read(addr);
            end else begin
                // vmem writes carry a single byte
                if (addr[REGION_HI:REGION_LO] == 4'hc) begin
                    be = 4'b1000 >> lfsr_bits(2);
                end else begin
                    be = BE_W'(lfsr_bits(4));
                end
                cpu_write(addr, lfsr_bits(32), be);
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        dmem_read    = 1'b0;
        dmem_write   = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        dmem_be      = '0;
        disp_addr    = '0;
        lfsr         = 32'hdc9d_43cd;
        reset_window = 1'b1;
        chk_rd       = 1'b0;
        chk_fast     = 1'b0;
        chk_disp     = 1'b0;
        chk_bp       = 1'b0;
        stall_seen   = 1'b0;
        exp_rdata    = '0;
        exp_char     = '0;
        stall_q      = 1'b0;
        rdata_q      = '0;
        char_q       = '0;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge ui_clk);
        #1;
        rst_n = 1'b1;
        // first cycle after reset carries a write that needs the reset credits
        cpu_write(ADDR_W'(0), lfsr_bits(32), 4'hf);
        reset_window = 1'b0;

        // fill every bank word so later reads have a known value
        test_name = "init";
        for (int a = 1; a < N_INIT; a++) begin
            cpu_write(ADDR_W'(a), lfsr_bits(32), 4'hf);
        end
        write_then_read();
        overflow_bank_credits();
        write_video_lanes();
        access_io_windows();
        mix_random_accesses();

        repeat (4) @(posedge ui_clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: rtl/cpu_mem_interface.sv
`timescale 1ns/10ps

module cpu_mem_interface import mem_map_pkg::*, bus_pkg::*; #(
    parameter int NUM_BANKS    = 4,
    parameter int BANK_WORDS   = 64,
    parameter int BANK_CREDITS = 2
) (
    input  logic               ui_clk,
    input  logic               rst_n,
    input  logic               dmem_read,
    input  logic               dmem_write,
    input  logic [ADDR_W-1:0]  dmem_addr,
    input  logic [DATA_W-1:0]  dmem_wdata,
    input  logic [BE_W-1:0]    dmem_be,
    output logic [DATA_W-1:0]  dmem_rdata,
    output logic               mem_stall,
    input  logic [CHAR_AW-1:0] disp_addr,
    output logic [7:0]         disp_char
);

    logic               read_done;
    logic               zero_rsp;
    logic               char_we;
    logic [CHAR_AW-1:0] char_addr;
    logic [7:0]         char_data;

    bank_if bank_bus [NUM_BANKS] ();

    mem_req_router #(
        .NUM_BANKS    (NUM_BANKS),
        .BANK_CREDITS (BANK_CREDITS)
    ) u_router (
        .ui_clk     (ui_clk),
        .rst_n      (rst_n),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .read_done  (read_done),
        .mem_stall  (mem_stall),
        .zero_rsp   (zero_rsp),
        .char_we    (char_we),
        .char_addr  (char_addr),
        .char_data  (char_data),
        .banks      (bank_bus)
    );

    // interleaved main memory
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_banks
        mem_bank #(
            .BANK_WORDS   (BANK_WORDS),
            .BANK_CREDITS (BANK_CREDITS)
        ) u_bank (
            .ui_clk (ui_clk),
            .rst_n  (rst_n),
            .bus    (bank_bus[g])
        );
    end

    rsp_merger #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merger (
        .ui_clk     (ui_clk),
        .rst_n      (rst_n),
        .zero_rsp   (zero_rsp),
        .banks      (bank_bus),
        .dmem_rdata (dmem_rdata),
        .read_done  (read_done)
    );

    text_buffer u_text_buffer (
        .ui_clk    (ui_clk),
        .char_we   (char_we),
        .char_addr (char_addr),
        .char_data (char_data),
        .disp_addr (disp_addr),
        .disp_char (disp_char)
    );

endmodule

// File: rtl/text_buffer.sv
`timescale 1ns/10ps

module text_buffer import mem_map_pkg::*; (
    input  logic               ui_clk,
    input  logic               char_we,
    input  logic [CHAR_AW-1:0] char_addr,
    input  logic [7:0]         char_data,
    input  logic [CHAR_AW-1:0] disp_addr,
    output logic [7:0]         disp_char
);

    localparam int DEPTH = 2 ** CHAR_AW;

    logic [7:0] chars [DEPTH];

    ////////////////////////////////////////
    // CPU write side
    ////////////////////////////////////////

    always_ff @(posedge ui_clk) begin
        if (char_we) begin
            chars[char_addr] <= char_data;
        end
    end

    // display read port with one cycle latency
    always_ff @(posedge ui_clk) begin
        disp_char <= chars[disp_addr];
    end

endmodule

// File: rtl/rsp_merger.sv
`timescale 1ns/10ps

module rsp_merger import bus_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  logic              ui_clk,
    input  logic              rst_n,
    input  logic              zero_rsp,
    bank_if.sink              banks [NUM_BANKS],
    output logic [DATA_W-1:0] dmem_rdata,
    output logic              read_done
);

    logic [NUM_BANKS-1:0] rsp_vec;
    logic [DATA_W-1:0]    rsp_masked [NUM_BANKS];
    logic [DATA_W-1:0]    rsp_word;
    logic [DATA_W-1:0]    data_q;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_collect
        assign rsp_vec[g]    = banks[g].rsp_valid;
        assign rsp_masked[g] = banks[g].rsp_valid ? banks[g].rsp_data : '0;
    end

    // only one read in flight, so an OR picks the answering bank
    always_comb begin
        rsp_word = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            rsp_word = rsp_word | rsp_masked[i];
        end
    end

    always_ff @(posedge ui_clk) begin
        if (|rsp_vec) begin
            data_q <= rsp_word;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            read_done <= 1'b0;
        end else begin
            read_done <= |rsp_vec;
        end
    end

    assign dmem_rdata = (read_done && !zero_rsp) ? data_q : '0;

    a_single_rsp: assert property (@(posedge ui_clk) disable iff (!rst_n)
        $onehot0(rsp_vec));

endmodule

// File: rtl/mem_bank.sv
`timescale 1ns/10ps

module mem_bank import bus_pkg::*; #(
    parameter int BANK_WORDS   = 64,
    parameter int BANK_CREDITS = 2
) (
    input  logic ui_clk,
    input  logic rst_n,
    bank_if.bank bus
);

    localparam int PTR_W  = (BANK_CREDITS > 1) ? $clog2(BANK_CREDITS) : 1;
    localparam int CNT_W  = $clog2(BANK_CREDITS + 1);
    localparam int WORD_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    bank_req_t         q_mem [BANK_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              retire;
    bank_req_t         head;
    logic [WORD_W-1:0] word_sel;
    logic [DATA_W-1:0] mem [BANK_WORDS];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BANK_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // request queue
    ////////////////////////////////////////

    always_ff @(posedge ui_clk) begin
        if (bus.req_valid) begin
            q_mem[wr_ptr] <= bus.req;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (bus.req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (retire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(bus.req_valid) - CNT_W'(retire);
        end
    end

    // head entry retires every cycle the queue is not empty
    assign retire     = (count != '0);
    assign head       = q_mem[rd_ptr];
    assign word_sel   = WORD_W'(head.idx % BANK_WORDS);
    assign bus.credit = retire;

    ////////////////////////////////////////
    // word storage
    ////////////////////////////////////////

    always_ff @(posedge ui_clk) begin
        if (retire && head.write) begin
            for (int i = 0; i < BANK_BE_W; i++) begin
                if (head.be[i]) begin
                    mem[word_sel][8*i +: 8] <= head.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (retire && !head.write) begin
            bus.rsp_data <= mem[word_sel];
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= retire && !head.write;
        end
    end

    // router credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge ui_clk) disable iff (!rst_n)
        bus.req_valid |-> (count < CNT_W'(BANK_CREDITS)));

endmodule

// File: rtl/mem_req_router.sv
`timescale 1ns/10ps

module mem_req_router import mem_map_pkg::*, bus_pkg::*; #(
    parameter int NUM_BANKS    = 4,
    parameter int BANK_CREDITS = 2
) (
    input  logic                ui_clk,
    input  logic                rst_n,
    input  logic                dmem_read,
    input  logic                dmem_write,
    input  logic [ADDR_W-1:0]   dmem_addr,
    input  logic [DATA_W-1:0]   dmem_wdata,
    input  logic [BE_W-1:0]     dmem_be,
    input  logic                read_done,
    output logic                mem_stall,
    output logic                zero_rsp,
    output logic                char_we,
    output logic [CHAR_AW-1:0]  char_addr,
    output logic [7:0]          char_data,
    bank_if.src                 banks [NUM_BANKS]
);

    localparam int BSEL_W = $clog2(NUM_BANKS);
    localparam int CNT_W  = $clog2(BANK_CREDITS + 1);

    region_t           region;
    logic              is_main;
    logic [BSEL_W-1:0] bank_sel;
    logic              has_credit;
    logic              read_pending;
    logic              send_read;
    logic              send_write;
    logic              send;
    bank_req_t         next_req;
    logic [1:0]        lane;
    logic [CNT_W-1:0]  credit_cnt [NUM_BANKS];

    ////////////////////////////////////////
    // decode and flow control
    ////////////////////////////////////////

    assign region   = decode_region(dmem_addr);
    assign is_main  = (region == REGION_MAIN);
    // interleaved so the low address bits pick the bank
    assign bank_sel = dmem_addr[BSEL_W-1:0];

    assign has_credit = (credit_cnt[bank_sel] != '0);

    // a read goes out once, then waits for read_done
    assign send_read  = dmem_read && is_main && !read_pending && has_credit;
    assign send_write = dmem_write && is_main && has_credit;
    assign send       = send_read || send_write;

    assign mem_stall = is_main && ((dmem_write && !has_credit) || (dmem_read && !read_done));
    assign zero_rsp  = dmem_read && !is_main;

    always_comb begin
        next_req.write = dmem_write;
        next_req.idx   = BANK_IDX_W'(dmem_addr >> BSEL_W);
        next_req.data  = dmem_wdata;
        next_req.be    = dmem_be;
    end

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
        end else if (read_done) begin
            read_pending <= 1'b0;
        end else if (send_read) begin
            read_pending <= 1'b1;
        end
    end

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        logic sel;

        assign sel = send && (bank_sel == BSEL_W'(g));

        // one credit spent per send, one back per retire
        always_ff @(posedge ui_clk) begin
            if (!rst_n) begin
                credit_cnt[g]      <= CNT_W'(BANK_CREDITS);
                banks[g].req_valid <= 1'b0;
            end else begin
                credit_cnt[g]      <= credit_cnt[g] - CNT_W'(sel) + CNT_W'(banks[g].credit);
                banks[g].req_valid <= sel;
            end
        end

        always_ff @(posedge ui_clk) begin
            if (sel) begin
                banks[g].req <= next_req;
            end
        end

        a_credit_bound: assert property (@(posedge ui_clk) disable iff (!rst_n)
            credit_cnt[g] <= CNT_W'(BANK_CREDITS));
    end

    ////////////////////////////////////////
    // video byte lane
    ////////////////////////////////////////

    assign char_we = dmem_write && (region == REGION_VMEM);

    always_comb begin
        case (dmem_be)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            default: lane = 2'd3;
        endcase
    end

    assign char_data = dmem_wdata[8*lane +: 8];
    assign char_addr = {dmem_addr[CHAR_AW-3:0], lane};

    a_no_rw_overlap: assert property (@(posedge ui_clk) disable iff (!rst_n)
        !(dmem_read && dmem_write));

    a_vmem_onehot: assert property (@(posedge ui_clk) disable iff (!rst_n)
        char_we |-> $onehot(dmem_be));

endmodule

// File: rtl/bank_if.sv
`timescale 1ns/10ps

// credit based request/response link between router, bank and merger
interface bank_if import bus_pkg::*; ();

    // request path from router to bank
    logic              req_valid;
    bank_req_t         req;

    // one pulse per retired queue entry
    logic              credit;

    // read data back from the bank
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_data;

    modport src (
        output req_valid,
        output req,
        input  credit
    );

    modport bank (
        input  req_valid,
        input  req,
        output credit,
        output rsp_valid,
        output rsp_data
    );

    modport sink (
        input  rsp_valid,
        input  rsp_data
    );

endinterface

// File: rtl/bus_pkg.sv
package bus_pkg;

    ////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////

    localparam int DATA_W = 32;

    // one enable bit per byte of DATA_W
    localparam int BE_W = DATA_W / 8;

    ////////////////////////////////////////
    // bank side
    ////////////////////////////////////////

    // wider than any bank in use, banks keep the low bits only
    localparam int BANK_IDX_W = 16;

    // banks store full CPU words
    localparam int BANK_BE_W = BE_W;

    typedef struct packed {
        logic                  write;
        logic [BANK_IDX_W-1:0] idx;
        logic [DATA_W-1:0]     data;
        logic [BANK_BE_W-1:0]  be;
    } bank_req_t;

endpackage

// File: rtl/mem_map_pkg.sv
package mem_map_pkg;

    ////////////////////////////////////////
    // address layout
    ////////////////////////////////////////

    // word address from the CPU
    localparam int ADDR_W = 30;

    // top four address bits select the region
    localparam int REGION_HI = 29;
    localparam int REGION_LO = 26;
    localparam int RGN_W     = REGION_HI - REGION_LO + 1;

    // everything below VMEM_TAG is main memory
    localparam logic [RGN_W-1:0] VMEM_TAG     = 4'hc;
    localparam logic [RGN_W-1:0] TIMER_TAG    = 4'hd;
    localparam logic [RGN_W-1:0] KBD_TAG      = 4'he;
    localparam logic [RGN_W-1:0] UNMAPPED_TAG = 4'hf;

    // text buffer holds 2**CHAR_AW characters
    localparam int CHAR_AW = 6;

    typedef enum logic [2:0] {
        REGION_MAIN,
        REGION_VMEM,
        REGION_TIMER,
        REGION_KBD,
        REGION_UNMAPPED
    } region_t;

    function automatic region_t decode_region(input logic [ADDR_W-1:0] addr);
        region_t rgn;
        case (addr[REGION_HI:REGION_LO])
            VMEM_TAG:     rgn = REGION_VMEM;
            TIMER_TAG:    rgn = REGION_TIMER;
            KBD_TAG:      rgn = REGION_KBD;
            UNMAPPED_TAG: rgn = REGION_UNMAPPED;
            default:      rgn = REGION_MAIN;
        endcase
        return rgn;
    endfunction

endpackage
